// File: design/command_decoder.sv
//////////////////////////////
// turns received command bytes into framebuffer writes
// and the colour enable mask
//////////////////////////////
`timescale 1ns/1ps
`include "led_consts.svh"

module command_decoder import led_pkg::*; (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    fb_if.writer       fb,
    output rgb_t       rgb_enable
);

    decode_state_t                     state;
    opcode_t                           cur_op;   // opcode waiting for its value byte
    col_t                              x_reg;
    logic [$clog2(`LED_HEIGHT)-1:0]    y_reg;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state      <= DS_IDLE;
            fb.wr_en   <= 1'b0;
            fb.wr_addr <= '0;
            rgb_enable <= '1;  // all channels on
        end else begin
            fb.wr_en <= 1'b0;
            case (state)
                DS_IDLE: begin
                    if (rx_valid) begin
                        case (rx_byte)
                            OP_FILL:   state <= DS_WAIT_VALUE;
                            OP_PIXEL:  state <= DS_WAIT_X;
                            OP_ENABLE: state <= DS_WAIT_MASK;
                            default:   state <= DS_IDLE;  // unknown, ignore
                        endcase
                    end
                end
                DS_WAIT_X: if (rx_valid) state <= DS_WAIT_Y;
                DS_WAIT_Y: if (rx_valid) state <= DS_WAIT_VALUE;
                DS_WAIT_VALUE: begin
                    if (rx_valid) begin
                        fb.wr_en <= 1'b1;
                        if (cur_op == OP_FILL) begin
                            fb.wr_addr <= '0;
                            state      <= DS_FILLING;
                        end else begin
                            fb.wr_addr <= {y_reg, x_reg};
                            state      <= DS_IDLE;
                        end
                    end
                end
                DS_WAIT_MASK: begin
                    if (rx_valid) begin
                        rgb_enable <= rx_byte[2:0];
                        state      <= DS_IDLE;
                    end
                end
                DS_FILLING: begin
                    // one address per cycle, last one written as we leave
                    if (fb.wr_addr == '1) begin
                        state <= DS_IDLE;
                    end else begin
                        fb.wr_en   <= 1'b1;
                        fb.wr_addr <= fb.wr_addr + 1'b1;
                    end
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

    // operand capture
    always_ff @(posedge clk_root) begin
        if (rx_valid) begin
            case (state)
                DS_IDLE:       cur_op     <= opcode_t'(rx_byte);
                DS_WAIT_X:     x_reg      <= rx_byte[$bits(col_t)-1:0];
                DS_WAIT_Y:     y_reg      <= rx_byte[$bits(y_reg)-1:0];
                DS_WAIT_VALUE: fb.wr_data <= rx_byte;
                default: ;
            endcase
        end
    end

endmodule

// File: design/fb_if.sv
//////////////////////////////
// framebuffer write port and paired read port
//////////////////////////////
`timescale 1ns/1ps

interface fb_if import led_pkg::*; ();

    logic        wr_en;
    fb_addr_t    wr_addr;
    pixel_t      wr_data;   // lands at the same edge as wr_en

    logic        rd_en;
    col_t        rd_col;
    row_t        rd_row;
    pixel_pair_t rd_pair;   // valid one cycle after rd_en

    modport writer (output wr_en, wr_addr, wr_data);
    modport reader (output rd_en, rd_col, rd_row, input rd_pair);
    modport memory (input wr_en, wr_addr, wr_data, rd_en, rd_col, rd_row, output rd_pair);

endinterface

// File: design/framebuffer_ram.sv
//////////////////////////////
// pixel memory split into top and bottom half banks
// reads return the same column and row of both halves
//////////////////////////////
`timescale 1ns/1ps
`include "led_consts.svh"

module framebuffer_ram import led_pkg::*; (
    input  logic  clk_root,
    fb_if.memory  fb
);

    localparam int DEPTH = `LED_WIDTH * `LED_HALF;
    localparam int AW    = $clog2(DEPTH);

    pixel_t        bank_top    [DEPTH];
    pixel_t        bank_bottom [DEPTH];
    logic [AW-1:0] wr_index;
    logic          wr_bottom;  // y top bit picks the bank
    logic [AW-1:0] rd_index;

    assign wr_index  = fb.wr_addr[AW-1:0];
    assign wr_bottom = fb.wr_addr[AW];
    assign rd_index  = {fb.rd_row, fb.rd_col};

    always_ff @(posedge clk_root) begin
        if (fb.wr_en && !wr_bottom) bank_top[wr_index] <= fb.wr_data;
        if (fb.wr_en && wr_bottom) bank_bottom[wr_index] <= fb.wr_data;
    end

    always_ff @(posedge clk_root) begin
        if (fb.rd_en) begin
            fb.rd_pair.top    <= bank_top[rd_index];
            fb.rd_pair.bottom <= bank_bottom[rd_index];
        end
    end

endmodule

// File: design/led_consts.svh
//////////////////////////////
// panel geometry and timing constants for the led matrix driver
// included by the package and by any module that sizes from them
//////////////////////////////
`ifndef LED_CONSTS_SVH
`define LED_CONSTS_SVH

// panel geometry
`define LED_WIDTH          16
`define LED_HEIGHT         8
`define LED_HALF           4  // rows per half, scan row r drives r and r+4

// brightness bits per colour channel
`define LED_PLANES         2

// serial line, clk_root cycles per bit
`define UART_TICKS_PER_BIT 16

// output enable length of plane 0, doubled per plane
`define OE_BASE_TICKS      8

`endif

// File: design/led_matrix_top.sv
//////////////////////////////
// led matrix driver top, serial commands in and hub75 panel out
//////////////////////////////
`timescale 1ns/1ps
`include "led_consts.svh"

module led_matrix_top import led_pkg::*; (
    input  logic clk_root,
    input  logic rst_n,
    input  logic serial_in,
    output rgb_t rgb_top,
    output rgb_t rgb_bottom,
    output row_t row_addr,
    output logic clk_pixel,
    output logic row_latch,
    output logic oe_n
);

    logic [7:0]                     rx_byte;
    logic                           rx_valid;
    rgb_t                           rgb_enable;
    logic                           fetch_req;
    col_t                           scan_col;
    row_t                           scan_row;
    logic [$clog2(`LED_PLANES)-1:0] scan_plane;

    fb_if fb_bus ();

    serial_rx u_serial_rx (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .serial_in(serial_in),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    command_decoder u_command_decoder (
        .clk_root  (clk_root),
        .rst_n     (rst_n),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .fb        (fb_bus.writer),
        .rgb_enable(rgb_enable)
    );

    framebuffer_ram u_framebuffer_ram (
        .clk_root(clk_root),
        .fb      (fb_bus.memory)
    );

    pixel_fetch u_pixel_fetch (
        .clk_root  (clk_root),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .col       (scan_col),
        .row       (scan_row),
        .plane     (scan_plane),
        .rgb_enable(rgb_enable),
        .fb        (fb_bus.reader),
        .rgb_top   (rgb_top),
        .rgb_bottom(rgb_bottom)
    );

    matrix_scan u_matrix_scan (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .fetch_req(fetch_req),
        .col      (scan_col),
        .row      (scan_row),
        .plane    (scan_plane),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .oe_n     (oe_n),
        .row_addr (row_addr)
    );

endmodule

// File: design/led_pkg.sv
//////////////////////////////
// shared types for the led matrix driver
// import with led_pkg::* in the module header
//////////////////////////////
`include "led_consts.svh"

package led_pkg;

    typedef enum logic [7:0] {
        OP_ENABLE = 8'h45,  // one mask byte
        OP_FILL   = 8'h46,  // one value byte
        OP_PIXEL  = 8'h50   // x, y, value
    } opcode_t;

    typedef enum logic [2:0] {
        DS_IDLE,
        DS_WAIT_X,
        DS_WAIT_Y,
        DS_WAIT_VALUE,
        DS_WAIT_MASK,
        DS_FILLING
    } decode_state_t;

    typedef enum logic [2:0] {
        SC_FETCH,
        SC_SHIFT_HIGH,
        SC_SHIFT_LOW,
        SC_LATCH,
        SC_DISPLAY
    } scan_state_t;

    typedef struct packed {
        logic [1:0] unused;
        logic [1:0] blue;
        logic [1:0] green;
        logic [1:0] red;
    } pixel_t;

    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    typedef logic [$clog2(`LED_WIDTH*`LED_HEIGHT)-1:0] fb_addr_t;  // {y, x}
    typedef logic [$clog2(`LED_WIDTH)-1:0] col_t;
    typedef logic [$clog2(`LED_HALF)-1:0] row_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

endpackage

// File: design/matrix_scan.sv
//////////////////////////////
// panel scan sequencer: shift, latch, then binary weighted display
// per row and bit plane
//////////////////////////////
`timescale 1ns/1ps
`include "led_consts.svh"

module matrix_scan import led_pkg::*; (
    input  logic                             clk_root,
    input  logic                             rst_n,
    output logic                             fetch_req,
    output col_t                             col,
    output row_t                             row,
    output logic [$clog2(`LED_PLANES)-1:0]   plane,
    output logic                             clk_pixel,
    output logic                             row_latch,
    output logic                             oe_n,
    output row_t                             row_addr
);

    localparam int PW     = $clog2(`LED_PLANES);
    localparam int OE_MAX = `OE_BASE_TICKS << (`LED_PLANES - 1);
    localparam int DW     = $clog2(OE_MAX + 1);

    scan_state_t   state;
    logic          fetch_wait;  // second cycle of a column fetch
    logic [DW-1:0] disp_cnt;
    logic [DW-1:0] oe_ticks;
    logic          last_col;
    logic          last_plane;

    assign oe_ticks   = DW'(`OE_BASE_TICKS) << plane;
    assign last_col   = col == col_t'(`LED_WIDTH - 1);
    assign last_plane = plane == PW'(`LED_PLANES - 1);

    // panel strobes straight from the state
    assign fetch_req = (state == SC_FETCH) && !fetch_wait;
    assign clk_pixel = state == SC_SHIFT_HIGH;
    assign row_latch = state == SC_LATCH;
    assign oe_n      = !((state == SC_DISPLAY) && (disp_cnt < oe_ticks));

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state      <= SC_FETCH;
            fetch_wait <= 1'b0;
            col        <= '0;
            row        <= '0;
            plane      <= '0;
            disp_cnt   <= '0;
            row_addr   <= '0;
        end else begin
            case (state)
                SC_FETCH: begin
                    fetch_wait <= !fetch_wait;
                    if (fetch_wait) state <= SC_SHIFT_HIGH;  // pixel data ready
                end
                SC_SHIFT_HIGH: state <= SC_SHIFT_LOW;
                SC_SHIFT_LOW: begin
                    col <= col + 1'b1;  // wraps to 0 after the last column
                    if (last_col) begin
                        row_addr <= row;  // shows with the latch
                        state    <= SC_LATCH;
                    end else begin
                        state <= SC_FETCH;
                    end
                end
                SC_LATCH: begin
                    disp_cnt <= '0;
                    state    <= SC_DISPLAY;
                end
                SC_DISPLAY: begin
                    // one blank cycle once the count is reached
                    if (disp_cnt == oe_ticks) begin
                        state <= SC_FETCH;
                        if (last_plane) begin
                            plane <= '0;
                            row   <= (row == row_t'(`LED_HALF - 1)) ? '0 : row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        disp_cnt <= disp_cnt + 1'b1;
                    end
                end
                default: state <= SC_FETCH;
            endcase
        end
    end

endmodule

// File: design/pixel_fetch.sv
//////////////////////////////
// reads a pixel pair and picks the current plane bit per channel
//////////////////////////////
`timescale 1ns/1ps
`include "led_consts.svh"

module pixel_fetch import led_pkg::*; (
    input  logic                             clk_root,
    input  logic                             rst_n,
    input  logic                             fetch_req,
    input  col_t                             col,
    input  row_t                             row,
    input  logic [$clog2(`LED_PLANES)-1:0]   plane,
    input  rgb_t                             rgb_enable,
    fb_if.reader                             fb,
    output rgb_t                             rgb_top,
    output rgb_t                             rgb_bottom
);

    localparam int PW = $clog2(`LED_PLANES);

    logic pair_valid;  // rd_pair holds the requested column

    function automatic rgb_t plane_bits(input pixel_t px, input logic [PW-1:0] p);
        rgb_t c;
        c.red   = px.red[p];
        c.green = px.green[p];
        c.blue  = px.blue[p];
        return c;
    endfunction

    assign fb.rd_en  = fetch_req;
    assign fb.rd_col = col;
    assign fb.rd_row = row;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            pair_valid <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            pair_valid <= fetch_req;
            if (pair_valid) begin
                rgb_top    <= plane_bits(fb.rd_pair.top, plane) & rgb_enable;
                rgb_bottom <= plane_bits(fb.rd_pair.bottom, plane) & rgb_enable;
            end
        end
    end

endmodule

// File: design/serial_rx.sv
//////////////////////////////
// 8N1 serial receiver with input synchroniser
// strobes rx_valid for one cycle per good byte
//////////////////////////////
`timescale 1ns/1ps
`include "led_consts.svh"

module serial_rx (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       serial_in,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int TW = $clog2(`UART_TICKS_PER_BIT);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    logic [1:0]    sync_ff;
    logic          rx_s;       // synchronised line
    rx_state_t     state;
    logic [TW-1:0] tick_cnt;
    logic [2:0]    bit_cnt;
    logic          tick_end;
    logic          tick_half;

    assign rx_s      = sync_ff[1];
    assign tick_end  = tick_cnt == TW'(`UART_TICKS_PER_BIT - 1);
    assign tick_half = tick_cnt == TW'(`UART_TICKS_PER_BIT / 2 - 1);

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            sync_ff <= 2'b11;  // line idles high
        end else begin
            sync_ff <= {sync_ff[0], serial_in};
        end
    end

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_s) state <= RX_START;
                end
                RX_START: begin
                    if (tick_half) begin  // middle of start bit
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_s ? RX_IDLE : RX_DATA;  // glitch, back to idle
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_end) begin
                        rx_valid <= rx_s;  // drop framing errors
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk_root) begin
        if (state == RX_DATA && tick_end) rx_byte <= {rx_s, rx_byte[7:1]};
    end

endmodule

// File: flist.f
+incdir+design
design/led_pkg.sv
design/fb_if.sv
design/serial_rx.sv
design/command_decoder.sv
design/framebuffer_ram.sv
design/pixel_fetch.sv
design/matrix_scan.sv
design/led_matrix_top.sv
sim/scan_checker.sv
sim/tb_led_matrix.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the led matrix testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_led_matrix -o tb_led_matrix

./obj_dir/tb_led_matrix | tee sim.log

# pass only when the testbench printed its pass line
grep -qF '*** TEST PASSED ***' sim.log
echo "simulation passed"

// File: sim/led_testdata.txt
// columns: test, kind (00 send bytes, 01 random frame, 02 check frame), byte count, bytes 0..3
// command bytes: 46 fill value, 50 pixel x y value, 45 colour mask
01 02 00 00 00 00 00
02 00 02 46 00 00 00
02 02 00 00 00 00 00
02 00 02 46 3f 00 00
02 02 00 00 00 00 00
03 00 02 46 15 00 00
03 00 04 50 00 00 24
03 00 04 50 0f 03 19
03 00 04 50 00 04 06
03 00 04 50 0f 07 31
03 00 04 50 07 02 2a
03 00 04 50 08 05 c9
03 02 00 00 00 00 00
04 00 02 45 02 00 00
04 02 00 00 00 00 00
04 00 02 45 07 00 00
04 02 00 00 00 00 00
05 01 00 00 00 00 00
05 00 02 13 a7 00 00
05 00 01 ff 00 00 00
05 00 04 50 05 06 3c
05 02 00 00 00 00 00

// File: sim/scan_checker.sv
//////////////////////////////
// hub75 output checker, samples the panel side at the falling clock edge
// the testbench loads the expected frame through its tasks
//////////////////////////////
`timescale 1ns/1ps
`include "led_consts.svh"

module scan_checker import led_pkg::*; (
    input  logic clk_root,
    input  logic rst_n,
    input  rgb_t rgb_top,
    input  rgb_t rgb_bottom,
    input  row_t row_addr,
    input  logic clk_pixel,
    input  logic row_latch,
    input  logic oe_n,
    output int   error_count,
    output int   frame_count,
    output int   first_latches
);

    localparam int LINES = `LED_HALF * `LED_PLANES;

    logic [7:0] exp_frame [`LED_WIDTH*`LED_HEIGHT];  // indexed {y, x}
    rgb_t       exp_enable = 3'b111;
    int         verify_req = 0;
    bit         verify_pixels = 1'b0;
    int         verify_seen = 0;
    int         lines_left = 0;
    int         errors = 0;
    int         frames = 0;
    int         row0_latches = 0;
    rgb_t       line_top [`LED_WIDTH];
    rgb_t       line_bottom [`LED_WIDTH];
    logic [4:0] col_cnt;
    int         low_cnt;
    row_t       model_row;     // row of the next latch
    logic       model_plane;
    logic       disp_plane;    // plane now on display
    logic       pix_prev;
    logic       oe_prev;
    bit         latched_once;
    bit         shown;         // oe pulse since the last latch

    assign error_count   = errors;
    assign frame_count   = frames;
    assign first_latches = row0_latches;

    task automatic mismatch(input string sig, input int expv, input int gotv);
        errors++;
        $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, expv, gotv);
    endtask

    task automatic fault(input string what);
        errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic expect_fill(input logic [7:0] v);
        int i;
        for (i = 0; i < `LED_WIDTH*`LED_HEIGHT; i++) exp_frame[i] = v;
    endtask

    task automatic store_pixel(input logic [3:0] x, input logic [2:0] y, input logic [7:0] v);
        exp_frame[{y, x}] = v;
    endtask

    task automatic apply_mask(input rgb_t m);
        exp_enable = m;
    endtask

    // next 8 lines are compared, pixels only once the frame is known
    task automatic start_verify(input bit pixels);
        verify_pixels = pixels;
        verify_req++;
    endtask

    // channel c shows bit 2c+p of the pixel byte
    function automatic rgb_t expected_rgb(input logic [7:0] v, input logic p);
        rgb_t c;
        c.red   = v[{2'd0, p}];
        c.green = v[{2'd1, p}];
        c.blue  = v[{2'd2, p}];
        return c & exp_enable;
    endfunction

    task automatic compare_line();
        logic [4:0] c;
        rgb_t       et;
        rgb_t       eb;
        for (c = 5'd0; c < 5'(`LED_WIDTH); c = c + 5'd1) begin
            et = expected_rgb(exp_frame[{1'b0, model_row, c[3:0]}], model_plane);
            eb = expected_rgb(exp_frame[{1'b1, model_row, c[3:0]}], model_plane);
            if (line_top[c[3:0]] != et) begin
                mismatch($sformatf("rgb_top col %0d row %0d plane %0d", c, model_row,
                    model_plane), int'(et), int'(line_top[c[3:0]]));
            end
            if (line_bottom[c[3:0]] != eb) begin
                mismatch($sformatf("rgb_bottom col %0d row %0d plane %0d", c, model_row,
                    model_plane), int'(eb), int'(line_bottom[c[3:0]]));
            end
        end
    endtask

    always @(negedge clk_root) begin
        if (!rst_n) begin
            if (oe_n != 1'b1) mismatch("oe_n in reset", 1, int'(oe_n));
            if (clk_pixel != 1'b0) mismatch("clk_pixel in reset", 0, int'(clk_pixel));
            if (row_latch != 1'b0) mismatch("row_latch in reset", 0, int'(row_latch));
            if (row_addr != 2'd0) mismatch("row_addr in reset", 0, int'(row_addr));
            col_cnt      = 5'd0;
            low_cnt      = 0;
            model_row    = 2'd0;
            model_plane  = 1'b0;
            disp_plane   = 1'b0;
            pix_prev     = 1'b0;
            oe_prev      = 1'b1;
            latched_once = 1'b0;
            shown        = 1'b0;
            lines_left   = 0;
            verify_seen  = verify_req;
        end else begin
            if (clk_pixel && !pix_prev) begin  // rising pixel clock
                if (col_cnt < 5'(`LED_WIDTH)) begin
                    line_top[col_cnt[3:0]]    = rgb_top;
                    line_bottom[col_cnt[3:0]] = rgb_bottom;
                end
                if (col_cnt != 5'd31) col_cnt = col_cnt + 5'd1;
            end

            if (!oe_n) begin
                low_cnt++;
                if (clk_pixel || row_latch) fault("oe_n low while shifting or latching");
            end else if (!oe_prev) begin
                if (low_cnt != (`OE_BASE_TICKS << disp_plane)) begin
                    mismatch($sformatf("oe_n low cycles, plane %0d", disp_plane),
                        `OE_BASE_TICKS << disp_plane, low_cnt);
                end
                low_cnt = 0;
                shown   = 1'b1;
            end

            if (row_latch) begin
                if (col_cnt != 5'(`LED_WIDTH)) mismatch("clk_pixel edges per latch",
                    `LED_WIDTH, int'(col_cnt));
                if (row_addr != model_row) mismatch("row_addr", int'(model_row), int'(row_addr));
                if (latched_once && !shown) fault("no output enable pulse between latches");
                if (verify_req != verify_seen) begin
                    verify_seen = verify_req;
                    lines_left  = LINES;
                end
                if (lines_left > 0) begin
                    if (verify_pixels) compare_line();
                    lines_left--;
                    if (lines_left == 0) frames++;
                end
                if (model_row == 2'd0 && !model_plane) row0_latches++;
                disp_plane   = model_plane;
                latched_once = 1'b1;
                shown        = 1'b0;
                col_cnt      = 5'd0;
                if (model_plane) model_row = model_row + 2'd1;  // planes 0,1 then next row
                model_plane = !model_plane;
            end

            pix_prev = clk_pixel;
            oe_prev  = oe_n;
        end
    end

endmodule

// File: sim/tb_led_matrix.sv
//////////////////////////////
// led matrix driver testbench that runs the records of sim/led_testdata.txt
// over the serial line and lets scan_checker compare the panel side
//////////////////////////////
`timescale 1ns/1ps
`include "led_consts.svh"

module tb_led_matrix import led_pkg::*; ();

    localparam int REC_BYTES   = 7;     // test, kind, count, b0..b3
    localparam int MAX_RECS    = 64;
    localparam int WAIT_CYCLES = 4000;  // a frame is about 630 cycles

    logic clk_root = 1'b0;
    logic rst_n;
    logic serial_in;
    rgb_t rgb_top;
    rgb_t rgb_bottom;
    row_t row_addr;
    logic clk_pixel;
    logic row_latch;
    logic oe_n;
    int   error_count;
    int   frame_count;
    int   first_latches;

    logic [7:0] tdata [(MAX_RECS+1)*REC_BYTES];
    bit         frame_known = 1'b0;  // every pixel written at least once

    always #2 clk_root = ~clk_root;

    led_matrix_top dut (
        .clk_root  (clk_root),
        .rst_n     (rst_n),
        .serial_in (serial_in),
        .rgb_top   (rgb_top),
        .rgb_bottom(rgb_bottom),
        .row_addr  (row_addr),
        .clk_pixel (clk_pixel),
        .row_latch (row_latch),
        .oe_n      (oe_n)
    );

    scan_checker scan_chk (
        .clk_root     (clk_root),
        .rst_n        (rst_n),
        .rgb_top      (rgb_top),
        .rgb_bottom   (rgb_bottom),
        .row_addr     (row_addr),
        .clk_pixel    (clk_pixel),
        .row_latch    (row_latch),
        .oe_n         (oe_n),
        .error_count  (error_count),
        .frame_count  (frame_count),
        .first_latches(first_latches)
    );

    // 8N1 framing sent lsb first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk_root);
            serial_in <= frame[0];
            frame = frame >> 1;
            repeat (`UART_TICKS_PER_BIT - 1) @(posedge clk_root);
        end
    endtask

    task automatic mirror_command(input logic [7:0] op, a, b, c);
        case (op)
            8'h46: begin
                scan_chk.expect_fill(a);
                frame_known = 1'b1;
            end
            8'h50: scan_chk.store_pixel(a[3:0], b[2:0], c);
            8'h45: scan_chk.apply_mask(a[2:0]);
            default: ;  // DUT drops unknown opcodes
        endcase
    endtask

    task automatic send_random_frame();
        logic [7:0] v;
        logic [3:0] x;
        logic [2:0] y;
        int         i;
        for (i = 0; i < `LED_WIDTH*`LED_HEIGHT; i++) begin
            {y, x} = 7'(i);
            v = 8'($urandom);
            send_byte(8'h50);
            send_byte({4'h0, x});
            send_byte({5'h0, y});
            send_byte(v);
            scan_chk.store_pixel(x, y, v);
        end
        frame_known = 1'b1;
    endtask

    task automatic wait_latches(input int count, output bit ok);
        int target;
        int t;
        target = first_latches + count;
        ok = 1'b0;
        for (t = 0; t < WAIT_CYCLES && !ok; t++) begin
            @(posedge clk_root);
            ok = first_latches >= target;
        end
        if (!ok) $display("timeout waiting for a row 0 plane 0 latch");
    endtask

    task automatic await_frame_check(output bit ok);
        int target;
        int t;
        target = frame_count + 1;
        ok = 1'b0;
        for (t = 0; t < WAIT_CYCLES && !ok; t++) begin
            @(posedge clk_root);
            ok = frame_count >= target;
        end
        if (!ok) $display("timeout waiting for the checker to finish a frame");
    endtask

    // let writes settle before one full frame is compared
    task automatic check_frame(output bit ok);
        wait_latches(1, ok);
        if (ok) wait_latches(1, ok);
        if (ok) begin
            scan_chk.start_verify(frame_known);
            await_frame_check(ok);
        end
    endtask

    task automatic run_record(input int base, output bit ok);
        logic [7:0] kind;
        logic [7:0] count;
        int         i;
        ok    = 1'b1;
        kind  = tdata[base + 1];
        count = tdata[base + 2];
        case (kind)
            8'h00: begin
                for (i = 0; i < int'(count); i++) send_byte(tdata[base + 3 + i]);
                mirror_command(tdata[base + 3], tdata[base + 4], tdata[base + 5],
                    tdata[base + 6]);
            end
            8'h01: send_random_frame();
            8'h02: check_frame(ok);
            default: begin
                $display("unknown record kind %0h in the test data", kind);
                ok = 1'b0;
            end
        endcase
    endtask

    initial begin
        int rec;
        int base;
        int tests_run;
        int test_start_errors;
        bit ok;
        rst_n     = 1'b0;
        serial_in = 1'b1;  // line idle
        void'($urandom(32'hda8061b4));
        for (rec = 0; rec < (MAX_RECS+1)*REC_BYTES; rec++) tdata[rec] = 8'hff;
        $readmemh("sim/led_testdata.txt", tdata);

        repeat (4) @(posedge clk_root);
        rst_n <= 1'b1;

        ok = 1'b1;
        tests_run = 0;
        test_start_errors = error_count;
        for (rec = 0; rec < MAX_RECS && ok && tdata[rec*REC_BYTES] != 8'hff; rec++) begin
            base = rec * REC_BYTES;
            run_record(base, ok);
            // next record starts another test
            if (!ok || tdata[base + REC_BYTES] != tdata[base]) begin
                tests_run++;
                $display("test %0d: %0s, %0d errors", tdata[base],
                    (ok && error_count == test_start_errors) ? "ok" : "failed",
                    error_count - test_start_errors);
                test_start_errors = error_count;
            end
        end

        $display("tests run %0d, errors %0d, aborted %0d", tests_run, error_count, int'(!ok));
        if (ok && error_count == 0 && tests_run > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
